// ==== design/exec_pkg.sv ====
/* integer execute stage shared types */

package exec_pkg;

    // warp geometry
    localparam int num_threads = 4;
    localparam int num_warps   = 4;
    localparam int warp_bits   = $clog2(num_warps);

    // datapath sizes
    localparam int xlen     = 32;
    localparam int reg_bits = 5;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_slt,
        op_beq,
        op_bne,
        op_blt,
        op_ebreak,
        op_ecall
    } alu_op_e;

    // one warp instruction as it leaves the issue stage
    typedef struct packed {
        logic [warp_bits-1:0]                 wid;
        logic [num_threads-1:0]               tmask;
        alu_op_e                              op;
        logic [xlen-1:0]                      pc;
        logic [xlen-1:0]                      offset;
        logic [reg_bits-1:0]                  rd;
        logic [num_threads-1:0][xlen-1:0]     rs1_data;
        logic [num_threads-1:0][xlen-1:0]     rs2_data;
    } dispatch_t;

    typedef struct packed {
        logic            active;
        alu_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
    } lane_req_t;

    // cond only means something for the branch opcodes
    typedef struct packed {
        logic            active;
        logic [xlen-1:0] result;
        logic            cond;
    } lane_rsp_t;

    // per-instruction fields that bypass the lanes
    typedef struct packed {
        logic [warp_bits-1:0]   wid;
        logic [num_threads-1:0] tmask;
        alu_op_e                op;
        logic [xlen-1:0]        pc;
        logic [xlen-1:0]        offset;
        logic [reg_bits-1:0]    rd;
    } lane_ctl_t;

    typedef struct packed {
        logic [warp_bits-1:0]             wid;
        logic [num_threads-1:0]           tmask;
        logic [xlen-1:0]                  pc;
        logic [reg_bits-1:0]              rd;
        logic                             wb;
        logic [num_threads-1:0][xlen-1:0] data;
    } commit_t;

    typedef struct packed {
        logic                 valid;
        logic [warp_bits-1:0] wid;
        logic                 taken;
        logic                 diverged;
        logic [xlen-1:0]      target;
    } branch_ctl_t;

    // opcode classes
    function automatic logic is_alu_op(alu_op_e op);
        return op inside {op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_slt};
    endfunction

    function automatic logic is_branch_op(alu_op_e op);
        return op inside {op_beq, op_bne, op_blt};
    endfunction

    function automatic logic is_trap_op(alu_op_e op);
        return op inside {op_ebreak, op_ecall};
    endfunction

endpackage

// ==== design/exec_dispatch.sv ====
/* dispatch register and lane fan-out */

`timescale 1ns/10ps

module exec_dispatch (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             dispatch_valid,
    input  exec_pkg::dispatch_t                              dispatch_data,
    input  logic                                             stall,
    output logic                                             dispatch_ready,
    output exec_pkg::lane_req_t [exec_pkg::num_threads-1:0]  lane_req,
    output logic                                             ctl_valid,
    output exec_pkg::lane_ctl_t                              ctl,
    output logic                                             sim_ebreak
);

    exec_pkg::dispatch_t inst_q;
    logic                inst_valid_q;
    logic                accept;
    logic                is_end_marker;

    // the whole pipeline moves together, so dispatch is free whenever commit is
    assign dispatch_ready = !stall;
    assign accept         = dispatch_valid && dispatch_ready;

    assign is_end_marker = exec_pkg::is_trap_op(dispatch_data.op)
                        && (dispatch_data.wid == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid_q <= 1'b0;
        end else if (!stall) begin
            // instructions with no live thread are swallowed here
            inst_valid_q <= dispatch_valid && (|dispatch_data.tmask);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= dispatch_data;
        end
    end

    // end-of-test marker for the simulation harness
    always_ff @(posedge clk) begin
        if (reset) begin
            sim_ebreak <= 1'b0;
        end else begin
            sim_ebreak <= accept && is_end_marker;
        end
    end

    // each thread gets its own operand pair, gated by its mask bit
    always_comb begin
        for (int i = 0; i < exec_pkg::num_threads; i++) begin
            lane_req[i].active = inst_valid_q && inst_q.tmask[i];
            lane_req[i].op     = inst_q.op;
            lane_req[i].a      = inst_q.rs1_data[i];
            lane_req[i].b      = inst_q.rs2_data[i];
        end
    end

    assign ctl_valid = inst_valid_q;

    always_comb begin
        ctl.wid    = inst_q.wid;
        ctl.tmask  = inst_q.tmask;
        ctl.op     = inst_q.op;
        ctl.pc     = inst_q.pc;
        ctl.offset = inst_q.offset;
        ctl.rd     = inst_q.rd;
    end

endmodule

// ==== design/exec_alu_lane.sv ====
/* single thread integer ALU */

`timescale 1ns/10ps

module exec_alu_lane (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  exec_pkg::lane_req_t req,
    output exec_pkg::lane_rsp_t rsp
);

    logic [exec_pkg::xlen-1:0] alu_result;
    logic                      br_cond;
    logic [4:0]                shamt;
    logic                      lt_signed;

    // only the low five bits of b count as a shift amount
    assign shamt     = req.b[4:0];
    assign lt_signed = $signed(req.a) < $signed(req.b);

    always_comb begin
        case (req.op)
            exec_pkg::op_add: alu_result = req.a + req.b;
            exec_pkg::op_sub: alu_result = req.a - req.b;
            exec_pkg::op_and: alu_result = req.a & req.b;
            exec_pkg::op_or:  alu_result = req.a | req.b;
            exec_pkg::op_xor: alu_result = req.a ^ req.b;
            exec_pkg::op_sll: alu_result = req.a << shamt;
            exec_pkg::op_srl: alu_result = req.a >> shamt;
            exec_pkg::op_slt: alu_result = {{(exec_pkg::xlen-1){1'b0}}, lt_signed};
            // branches and traps write nothing back
            default:          alu_result = '0;
        endcase
    end

    always_comb begin
        case (req.op)
            exec_pkg::op_beq: br_cond = (req.a == req.b);
            exec_pkg::op_bne: br_cond = (req.a != req.b);
            exec_pkg::op_blt: br_cond = lt_signed;
            default:          br_cond = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp.active <= 1'b0;
        end else if (!stall) begin
            rsp.active <= req.active;
        end
    end

    // a masked-off thread reports zero so commit sees clean data
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (req.active) begin
                rsp.result <= alu_result;
                rsp.cond   <= br_cond;
            end else begin
                rsp.result <= '0;
                rsp.cond   <= 1'b0;
            end
        end
    end

endmodule

// ==== design/exec_commit.sv ====
/* commit record build and branch resolve */

`timescale 1ns/10ps

module exec_commit (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            ctl_valid,
    input  exec_pkg::lane_ctl_t                             ctl,
    input  exec_pkg::lane_rsp_t [exec_pkg::num_threads-1:0] lane_rsp,
    input  logic                                            commit_ready,
    output logic                                            stall,
    output logic                                            commit_valid,
    output exec_pkg::commit_t                               commit_data,
    output exec_pkg::branch_ctl_t                           branch_ctl
);

    // sideband aligned with the lane result register
    exec_pkg::lane_ctl_t       ctl_q;
    logic                      ctl_valid_q;

    exec_pkg::commit_t         commit_next;
    logic                      br_taken;
    logic                      br_diverged;
    logic                      br_found;
    logic [exec_pkg::xlen-1:0] br_target;

    // the branch outcome is registered beside the commit record
    logic                      br_is_q;
    logic                      br_taken_q;
    logic                      br_diverged_q;
    logic [exec_pkg::xlen-1:0] br_target_q;

    assign stall = commit_valid && !commit_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_valid_q <= 1'b0;
        end else if (!stall) begin
            ctl_valid_q <= ctl_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ctl_q <= ctl;
        end
    end

    // the first live thread decides the branch and the rest are compared against it
    always_comb begin
        br_found    = 1'b0;
        br_taken    = 1'b0;
        br_diverged = 1'b0;
        for (int i = 0; i < exec_pkg::num_threads; i++) begin
            if (lane_rsp[i].active) begin
                if (!br_found) begin
                    br_found = 1'b1;
                    br_taken = lane_rsp[i].cond;
                end else if (lane_rsp[i].cond != br_taken) begin
                    br_diverged = 1'b1;
                end
            end
        end
    end

    assign br_target = br_taken ? (ctl_q.pc + ctl_q.offset) : (ctl_q.pc + 32'd4);

    always_comb begin
        commit_next.wid   = ctl_q.wid;
        commit_next.tmask = ctl_q.tmask;
        commit_next.pc    = ctl_q.pc;
        commit_next.rd    = ctl_q.rd;
        commit_next.wb    = exec_pkg::is_alu_op(ctl_q.op);
        for (int i = 0; i < exec_pkg::num_threads; i++) begin
            commit_next.data[i] = lane_rsp[i].result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (!stall) begin
            commit_valid <= ctl_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            commit_data   <= commit_next;
            br_is_q       <= exec_pkg::is_branch_op(ctl_q.op);
            br_taken_q    <= br_taken;
            br_diverged_q <= br_diverged;
            br_target_q   <= br_target;
        end
    end

    // the branch record fires on the same handshake that retires the commit
    always_comb begin
        branch_ctl.valid    = commit_valid && commit_ready && br_is_q;
        branch_ctl.wid      = commit_data.wid;
        branch_ctl.taken    = br_taken_q;
        branch_ctl.diverged = br_diverged_q;
        branch_ctl.target   = br_target_q;
    end

endmodule

// ==== design/exec_unit.sv ====
/* integer execute stage top */

`timescale 1ns/10ps

module exec_unit (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    dispatch_valid,
    output logic                    dispatch_ready,
    input  exec_pkg::dispatch_t     dispatch_data,

    output logic                    commit_valid,
    input  logic                    commit_ready,
    output exec_pkg::commit_t       commit_data,

    output exec_pkg::branch_ctl_t   branch_ctl,

    // end marker for the simulation harness
    output logic                    sim_ebreak
);

    exec_pkg::lane_req_t [exec_pkg::num_threads-1:0] lane_req;
    exec_pkg::lane_rsp_t [exec_pkg::num_threads-1:0] lane_rsp;
    exec_pkg::lane_ctl_t                             ctl;
    logic                                            ctl_valid;
    logic                                            stall;

    exec_dispatch i_dispatch (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_data  (dispatch_data),
        .stall          (stall),
        .dispatch_ready (dispatch_ready),
        .lane_req       (lane_req),
        .ctl_valid      (ctl_valid),
        .ctl            (ctl),
        .sim_ebreak     (sim_ebreak)
    );

    // one identical lane per thread
    for (genvar i = 0; i < exec_pkg::num_threads; i++) begin : g_lane
        exec_alu_lane i_lane (
            .clk   (clk),
            .reset (reset),
            .stall (stall),
            .req   (lane_req[i]),
            .rsp   (lane_rsp[i])
        );
    end

    exec_commit i_commit (
        .clk          (clk),
        .reset        (reset),
        .ctl_valid    (ctl_valid),
        .ctl          (ctl),
        .lane_rsp     (lane_rsp),
        .commit_ready (commit_ready),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .branch_ctl   (branch_ctl)
    );

endmodule

// ==== sim/exec_checker.sv ====
/* execute stage result checker */

`timescale 1ns/10ps

module exec_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  logic                  dispatch_ready,
    input  exec_pkg::dispatch_t   dispatch_data,
    input  logic                  commit_valid,
    input  logic                  commit_ready,
    input  exec_pkg::commit_t     commit_data,
    input  exec_pkg::branch_ctl_t branch_ctl,
    input  logic                  sim_ebreak,
    output int                    errors,
    output int                    commits,
    output int                    pending
);

    // accepted instructions that still owe a commit wait here oldest first
    exec_pkg::dispatch_t inflight[$];
    exec_pkg::dispatch_t oldest;
    logic                ebreak_due;
    int                  row_errors;

    function automatic logic [31:0] expected_result(input exec_pkg::alu_op_e op,
                                                    input logic [31:0] a, input logic [31:0] b);
        case (op)
            exec_pkg::op_add: return a + b;
            exec_pkg::op_sub: return a - b;
            exec_pkg::op_and: return a & b;
            exec_pkg::op_or:  return a | b;
            exec_pkg::op_xor: return a ^ b;
            exec_pkg::op_sll: return a << b[4:0];
            exec_pkg::op_srl: return a >> b[4:0];
            exec_pkg::op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:          return 32'd0;
        endcase
    endfunction

    function automatic logic expected_cond(input exec_pkg::alu_op_e op,
                                           input logic [31:0] a, input logic [31:0] b);
        case (op)
            exec_pkg::op_beq: return a == b;
            exec_pkg::op_bne: return a != b;
            exec_pkg::op_blt: return $signed(a) < $signed(b);
            default:          return 1'b0;
        endcase
    endfunction

    function automatic logic writes_back(input exec_pkg::alu_op_e op);
        case (op)
            exec_pkg::op_add, exec_pkg::op_sub, exec_pkg::op_and, exec_pkg::op_or,
            exec_pkg::op_xor, exec_pkg::op_sll, exec_pkg::op_srl, exec_pkg::op_slt: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_branch(input exec_pkg::alu_op_e op);
        return (op == exec_pkg::op_beq) || (op == exec_pkg::op_bne) || (op == exec_pkg::op_blt);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            row_errors++;
            errors++;
        end
    endtask

    task automatic check_commit(input exec_pkg::dispatch_t inst);
        exec_pkg::alu_op_e op;
        logic              found;
        logic              cond;
        logic              exp_taken;
        logic              exp_diverged;
        logic [31:0]       exp_data;
        op           = inst.op;
        row_errors   = 0;
        found        = 1'b0;
        exp_taken    = 1'b0;
        exp_diverged = 1'b0;
        check_value("commit_data.wid", inst.wid, commit_data.wid);
        check_value("commit_data.tmask", inst.tmask, commit_data.tmask);
        check_value("commit_data.pc", inst.pc, commit_data.pc);
        check_value("commit_data.rd", inst.rd, commit_data.rd);
        check_value("commit_data.wb", writes_back(op), commit_data.wb);
        for (int i = 0; i < exec_pkg::num_threads; i++) begin
            // masked-off threads write back zero
            exp_data = inst.tmask[i] ? expected_result(op, inst.rs1_data[i], inst.rs2_data[i]) : 0;
            if (writes_back(op)) begin
                check_value($sformatf("commit_data.data[%0d]", i), exp_data, commit_data.data[i]);
            end
            if (inst.tmask[i]) begin
                cond = expected_cond(op, inst.rs1_data[i], inst.rs2_data[i]);
                if (!found) begin
                    found     = 1'b1;
                    exp_taken = cond;
                end else if (cond != exp_taken) begin
                    exp_diverged = 1'b1;
                end
            end
        end
        check_value("branch_ctl.valid", is_branch(op), branch_ctl.valid);
        if (is_branch(op)) begin
            check_value("branch_ctl.wid", inst.wid, branch_ctl.wid);
            check_value("branch_ctl.taken", exp_taken, branch_ctl.taken);
            check_value("branch_ctl.diverged", exp_diverged, branch_ctl.diverged);
            check_value("branch_ctl.target", exp_taken ? inst.pc + inst.offset : inst.pc + 4,
                        branch_ctl.target);
        end
        commits++;
        $display("commit %0d: %s wid %0d pc %h %s", commits, op.name(), inst.wid, inst.pc,
                 (row_errors == 0) ? "ok" : "wrong");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            inflight.delete();
            ebreak_due = 1'b0;
            errors     = 0;
            commits    = 0;
        end else begin
            check_value("sim_ebreak", ebreak_due, sim_ebreak);
            // dispatch may only take a new instruction while commit is not held up
            check_value("dispatch_ready", commit_ready || !commit_valid, dispatch_ready);
            if (commit_valid && commit_ready) begin
                if (inflight.size() == 0) begin
                    $display("commit at %0t ns arrived with no instruction in flight", $time);
                    errors++;
                end else begin
                    oldest = inflight.pop_front();
                    check_commit(oldest);
                end
            end else begin
                check_value("branch_ctl.valid", 1'b0, branch_ctl.valid);
            end
            // the end marker follows an accepted trap on warp 0 by one cycle
            ebreak_due = dispatch_valid && dispatch_ready && (dispatch_data.wid == 0)
                      && ((dispatch_data.op == exec_pkg::op_ebreak)
                      || (dispatch_data.op == exec_pkg::op_ecall));
            if (dispatch_valid && dispatch_ready && (dispatch_data.tmask != 0)) begin
                inflight.push_back(dispatch_data);
            end
        end
        pending = inflight.size();
    end

endmodule

// ==== sim/exec_tb.sv ====
/* execute stage testbench */

`timescale 1ns/10ps

module exec_tb;

    // the per-thread operands of a row are a + i*a_step and b + i*b_step
    typedef struct packed {
        exec_pkg::alu_op_e                  op;
        logic [exec_pkg::num_threads-1:0]   mask;
        logic [exec_pkg::warp_bits-1:0]     wid;
        logic [31:0]                        pc;
        logic [31:0]                        offset;
        logic [31:0]                        a;
        logic [31:0]                        a_step;
        logic [31:0]                        b;
        logic [31:0]                        b_step;
        logic                               exp_commit;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  dispatch_valid;
    logic                  dispatch_ready;
    exec_pkg::dispatch_t   dispatch_data;
    logic                  commit_valid;
    logic                  commit_ready;
    exec_pkg::commit_t     commit_data;
    exec_pkg::branch_ctl_t branch_ctl;
    logic                  sim_ebreak;

    row_t   rows[$];
    integer seed;
    int     errors;
    int     commits;
    int     pending;
    int     expected_commits;
    int     cycles;
    int     cycle_limit;
    logic   accepted;

    exec_unit i_dut (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_data  (dispatch_data),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_data    (commit_data),
        .branch_ctl     (branch_ctl),
        .sim_ebreak     (sim_ebreak)
    );

    exec_checker i_checker (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_data  (dispatch_data),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_data    (commit_data),
        .branch_ctl     (branch_ctl),
        .sim_ebreak     (sim_ebreak),
        .errors         (errors),
        .commits        (commits),
        .pending        (pending)
    );

    always #2 clk = ~clk;

    // commit back-pressure leaves ready high about three cycles in four
    always @(negedge clk) begin
        commit_ready = ($random(seed) % 4) != 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d instructions still in flight",
                     cycles, pending);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic add_row(input exec_pkg::alu_op_e op, input logic [3:0] mask,
                           input logic [1:0] wid, input logic [31:0] pc, input logic [31:0] offset,
                           input logic [31:0] a, input logic [31:0] a_step,
                           input logic [31:0] b, input logic [31:0] b_step, input logic exp_commit);
        rows.push_back({op, mask, wid, pc, offset, a, a_step, b, b_step, exp_commit});
    endtask

    task automatic load_table();
        //      op                  mask wid pc      offset        a            a_step b      b_step
        add_row(exec_pkg::op_add,    'hf, 1, 'h100, 'h0,         'h7fff_ffff, 'h1,  'h1,   'h0,  1);
        add_row(exec_pkg::op_add,    'h5, 2, 'h104, 'h0,         'hffff_ffff, 'h0,  'h1,   'h1,  1);
        add_row(exec_pkg::op_sub,    'hf, 1, 'h108, 'h0,         'h0,         'h1,  'h1,   'h0,  1);
        add_row(exec_pkg::op_sub,    'ha, 3, 'h10c, 'h0,         'h8000_0000, 'h0,  'h1,   'h0,  1);
        add_row(exec_pkg::op_and,    'hf, 1, 'h110, 'h0,         'hf0f0_f0f0, 'hf,  'hff00_ff00, 'h1, 1);
        add_row(exec_pkg::op_or,     'h3, 2, 'h114, 'h0,         'h1234_0000, 'h1,  'h5678, 'h10, 1);
        add_row(exec_pkg::op_xor,    'hf, 1, 'h118, 'h0,         'haaaa_aaaa, 'h0,  'hffff_ffff, 'h5555_5555, 1);
        add_row(exec_pkg::op_sll,    'hf, 1, 'h11c, 'h0,         'h8000_0001, 'h0,  'h1f,  'h1,  1);
        add_row(exec_pkg::op_srl,    'hf, 2, 'h120, 'h0,         'h8000_0000, 'h0,  'h1f,  'h1,  1);
        add_row(exec_pkg::op_srl,    'h9, 3, 'h124, 'h0,         'hffff_ffff, 'h0,  'h3e0, 'h7,  1);
        add_row(exec_pkg::op_slt,    'hf, 1, 'h128, 'h0,         'hffff_fffe, 'h1,  'h0,   'h0,  1);
        add_row(exec_pkg::op_slt,    'hf, 1, 'h12c, 'h0,         'h7fff_ffff, 'h0,  'h8000_0000, 'h0, 1);
        add_row(exec_pkg::op_add,    'h0, 1, 'h130, 'h0,         'h1,         'h0,  'h1,   'h0,  0);
        add_row(exec_pkg::op_beq,    'hf, 1, 'h200, 'h40,        'h5,         'h0,  'h5,   'h0,  1);
        add_row(exec_pkg::op_beq,    'hf, 2, 'h204, 'hffff_fff8, 'h5,         'h1,  'h5,   'h0,  1);
        add_row(exec_pkg::op_bne,    'he, 1, 'h208, 'h100,       'h5,         'h1,  'h5,   'h0,  1);
        add_row(exec_pkg::op_bne,    'hf, 3, 'h20c, 'h20,        'h3,         'h0,  'h3,   'h0,  1);
        add_row(exec_pkg::op_blt,    'hf, 1, 'h210, 'h80,        'hffff_fffe, 'h1,  'h0,   'h0,  1);
        add_row(exec_pkg::op_blt,    'hc, 2, 'h214, 'h80,        'hffff_fffe, 'h1,  'h0,   'h0,  1);
        add_row(exec_pkg::op_ebreak, 'hf, 0, 'h300, 'h0,         'h0,         'h0,  'h0,   'h0,  1);
        add_row(exec_pkg::op_ecall,  'h1, 0, 'h304, 'h0,         'h0,         'h0,  'h0,   'h0,  1);
        add_row(exec_pkg::op_ebreak, 'hf, 1, 'h308, 'h0,         'h0,         'h0,  'h0,   'h0,  1);
        add_row(exec_pkg::op_ecall,  'hf, 2, 'h30c, 'h0,         'h0,         'h0,  'h0,   'h0,  1);
        add_row(exec_pkg::op_beq,    'h0, 0, 'h310, 'h40,        'h5,         'h0,  'h5,   'h0,  0);
    endtask

    function automatic exec_pkg::dispatch_t make_inst(input row_t row, input int idx);
        exec_pkg::dispatch_t inst;
        inst.wid    = row.wid;
        inst.tmask  = row.mask;
        inst.op     = row.op;
        inst.pc     = row.pc;
        inst.offset = row.offset;
        inst.rd     = idx[4:0] + 5'd1;
        for (int i = 0; i < exec_pkg::num_threads; i++) begin
            inst.rs1_data[i] = row.a + i * row.a_step;
            inst.rs2_data[i] = row.b + i * row.b_step;
        end
        return inst;
    endfunction

    initial begin
        clk              = 1'b0;
        reset            = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_data    = '0;
        commit_ready     = 1'b0;
        seed             = 30;
        cycles           = 0;
        expected_commits = 0;
        load_table();
        cycle_limit = rows.size() * 10 + 100;

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // each row is held on the bus until the DUT takes it
        for (int r = 0; r < rows.size(); r++) begin
            dispatch_valid    = 1'b1;
            dispatch_data     = make_inst(rows[r], r);
            expected_commits += rows[r].exp_commit;
            accepted          = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                accepted = dispatch_ready;
                @(negedge clk);
            end
        end
        dispatch_valid = 1'b0;
        dispatch_data  = '0;

        while (pending != 0) @(negedge clk);
        repeat (4) @(negedge clk);

        if (commits != expected_commits) begin
            $display("wrong number of commits, expected %0d but saw %0d",
                     expected_commits, commits);
        end
        $display("%0d commits checked, %0d errors", commits, errors);
        if ((errors == 0) && (commits == expected_commits)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
design/exec_pkg.sv
design/exec_dispatch.sv
design/exec_alu_lane.sv
design/exec_commit.sv
design/exec_unit.sv
sim/exec_checker.sv
sim/exec_tb.sv
